//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;

    // addi x0, x0, 0
    localparam word_t NOP_IR = 32'h0000_0013;
    // bubble marker, never a real pc
    localparam word_t NOP_PC = 32'hffff_ffff;

    // funct3 values used by the expander
    localparam logic [2:0] F3_ADD  = 3'b000; // addi and add
    localparam logic [2:0] F3_WORD = 3'b010; // lw and sw

    // base opcodes the expander can produce
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        OP     = 7'b0110011,
        JAL    = 7'b1101111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // recognized compressed forms
    typedef enum logic [3:0] {
        RVC_ADDI,      // also c.nop
        RVC_LI,
        RVC_LUI,
        RVC_MV,
        RVC_ADD,
        RVC_J,
        RVC_LW,
        RVC_SW,
        RVC_ILLEGAL
    } rvc_op_t;

endpackage

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // instruction memory geometry
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS); // word address bits

    // alignment state machine, one-hot
    typedef enum logic [4:0] {
        STARTUP        = 5'b00001,
        ALIGNED        = 5'b00010,
        UNALIGNED      = 5'b00100, // upper half of last word is saved
        UNALIGNED_JUMP = 5'b01000, // second cycle of a halfword jump
        HALTED         = 5'b10000
    } fetch_state_t;

endpackage

`default_nettype wire

//--- common/fetch_out_if.sv
`timescale 1ns/1ps
`default_nettype none

// one fetched instruction on its way to decode
interface fetch_out_if;
    import rv_isa_pkg::*;

    word_t pc;      // NOP_PC marks a bubble
    word_t ir;      // expanded instruction
    word_t next_pc;
    logic  ready;   // decode side takes the item on this edge

    modport stage (
        output pc,
        output ir,
        output next_pc,
        input  ready
    );

    modport sink (
        input  pc,
        input  ir,
        input  next_pc,
        output ready
    );

endinterface

`default_nettype wire

//--- fetch/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  wire rv_isa_pkg::word_t ir_i,
    output rv_isa_pkg::word_t      ir_o,
    output logic                   compressed_o
);
    import rv_isa_pkg::*;

    rvc_op_t     rvc_op_w;
    word_t       expanded_w;
    logic [4:0]  rd_w;      // full 5-bit register fields
    logic [4:0]  rs2_w;
    logic [4:0]  rd_p_w;    // 3-bit forms, x8 to x15
    logic [4:0]  rs1_p_w;
    logic [5:0]  imm6_w;
    logic [11:0] imm12_w;   // sign extended imm6
    logic [11:0] mem_off_w; // c.lw and c.sw word offset

    assign compressed_o = ir_i[1:0] != 2'b11;

    assign rd_w      = ir_i[11:7];
    assign rs2_w     = ir_i[6:2];
    assign rd_p_w    = {2'b01, ir_i[4:2]};
    assign rs1_p_w   = {2'b01, ir_i[9:7]};
    assign imm6_w    = {ir_i[12], ir_i[6:2]};
    assign imm12_w   = {{6{imm6_w[5]}}, imm6_w};
    assign mem_off_w = {5'b0, ir_i[5], ir_i[12:10], ir_i[6], 2'b00};

    always_comb begin
        // classify on funct3 and quadrant
        rvc_op_w = RVC_ILLEGAL;
        case ({ir_i[15:13], ir_i[1:0]})
            5'b010_00: rvc_op_w = RVC_LW;
            5'b110_00: rvc_op_w = RVC_SW;
            5'b000_01: rvc_op_w = RVC_ADDI;
            5'b010_01: rvc_op_w = RVC_LI;
            5'b011_01: begin
                // rd of x2 is c.addi16sp, zero imm is reserved
                if (rd_w != 5'd0 && rd_w != 5'd2 && imm6_w != 6'd0) begin
                    rvc_op_w = RVC_LUI;
                end
            end
            5'b101_01: rvc_op_w = RVC_J;
            5'b100_10: begin
                if (rs2_w != 5'd0) begin // rs2 of x0 is jr, jalr or ebreak
                    rvc_op_w = ir_i[12] ? RVC_ADD : RVC_MV;
                end
            end
            default: rvc_op_w = RVC_ILLEGAL;
        endcase

        case (rvc_op_w)
            RVC_ADDI: expanded_w = {imm12_w, rd_w, F3_ADD, rd_w, OP_IMM};
            RVC_LI:   expanded_w = {imm12_w, 5'd0, F3_ADD, rd_w, OP_IMM};
            RVC_LUI:  expanded_w = {{14{imm6_w[5]}}, imm6_w, rd_w, LUI};
            RVC_MV:   expanded_w = {7'd0, rs2_w, 5'd0, F3_ADD, rd_w, OP};
            RVC_ADD:  expanded_w = {7'd0, rs2_w, rd_w, F3_ADD, rd_w, OP};
            RVC_J: begin
                // jal x0 with the scrambled c.j offset
                expanded_w = {ir_i[12], ir_i[8], ir_i[10:9], ir_i[6], ir_i[7], ir_i[2],
                              ir_i[11], ir_i[5:3], ir_i[12], {8{ir_i[12]}}, 5'd0, JAL};
            end
            RVC_LW:   expanded_w = {mem_off_w, rs1_p_w, F3_WORD, rd_p_w, LOAD};
            RVC_SW: begin
                expanded_w = {mem_off_w[11:5], rd_p_w, rs1_p_w, F3_WORD,
                              mem_off_w[4:0], STORE};
            end
            default:  expanded_w = '0; // illegal instruction
        endcase

        if (compressed_o && rvc_op_w != RVC_ILLEGAL) begin
            assert (expanded_w != '0);
        end
    end

    assign ir_o = compressed_o ? expanded_w : ir_i;

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              halt_i,
    input  wire logic              jmp_valid_i,
    input  wire rv_isa_pkg::word_t jmp_addr_i,
    output rv_isa_pkg::word_t      imem_addr_o,
    input  wire rv_isa_pkg::word_t imem_data_i,
    fetch_out_if.stage             out
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    fetch_state_t state_r;
    fetch_state_t state_w;

    word_t imem_addr_r;     // byte address of the word now on imem_data_i
    word_t imem_addr_w;
    word_t next_pc_r;
    word_t next_pc_w;
    word_t pc_r;
    word_t ir_r;
    word_t jmp_addr_r;      // target of a halfword jump
    logic [15:0] saved_hi_r; // upper half of the previous word

    logic go_w;
    logic jump_w;
    logic issue_w;          // an instruction leaves this cycle
    logic bubble_w;         // outputs become a bubble
    logic save_hi_w;

    word_t raw_ir_w;
    word_t expanded_ir_w;
    logic  compressed_w;

    assign go_w   = out.ready && !halt_i;
    assign jump_w = go_w && jmp_valid_i;

    // bits handed to the expander depend on where the instruction starts
    always_comb begin
        case (state_r)
            ALIGNED:   raw_ir_w = imem_data_i;
            UNALIGNED: raw_ir_w = {imem_data_i[15:0], saved_hi_r};
            default:   raw_ir_w = NOP_IR;
        endcase
    end

    rvc_expander expander_i (
        .ir_i         (raw_ir_w),
        .ir_o         (expanded_ir_w),
        .compressed_o (compressed_w)
    );

    // next state, next address and output control
    always_comb begin
        state_w     = state_r;
        imem_addr_w = imem_addr_r;   // default is to re-read the same word
        next_pc_w   = next_pc_r;
        issue_w     = 1'b0;
        bubble_w    = 1'b0;
        save_hi_w   = 1'b0;

        if (jump_w) begin
            // jump wins over halt and over the current instruction
            bubble_w    = 1'b1;
            imem_addr_w = {jmp_addr_i[31:2], 2'b00};
            next_pc_w   = jmp_addr_i;
            state_w     = jmp_addr_i[1] ? UNALIGNED_JUMP : ALIGNED;
        end else if (halt_i || state_r == HALTED) begin
            bubble_w  = 1'b1;
            next_pc_w = NOP_PC;
            state_w   = HALTED; // left only by a jump
        end else begin
            case (state_r)
                STARTUP: begin
                    bubble_w = 1'b1; // word 0 is being read
                    state_w  = ALIGNED;
                end
                ALIGNED: begin
                    if (out.ready) begin
                        issue_w     = 1'b1;
                        imem_addr_w = imem_addr_r + 32'd4;
                        if (compressed_w) begin
                            save_hi_w = 1'b1; // next one starts in the upper half
                            state_w   = UNALIGNED;
                        end
                    end
                end
                UNALIGNED: begin
                    if (out.ready) begin
                        issue_w = 1'b1;
                        if (compressed_w) begin
                            state_w = ALIGNED; // same word again, from its low half
                        end else begin
                            save_hi_w   = 1'b1;
                            imem_addr_w = imem_addr_r + 32'd4;
                        end
                    end
                end
                UNALIGNED_JUMP: begin
                    if (out.ready) begin
                        // keep the upper half of the target word
                        save_hi_w   = 1'b1;
                        imem_addr_w = imem_addr_r + 32'd4;
                        next_pc_w   = jmp_addr_r;
                        state_w     = UNALIGNED;
                    end
                end
                default: begin
                    bubble_w = 1'b1;
                    state_w  = HALTED;
                end
            endcase

            if (issue_w) begin
                next_pc_w = next_pc_r + (compressed_w ? 32'd2 : 32'd4);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_r     <= STARTUP;
            imem_addr_r <= '0;
            next_pc_r   <= '0;
            pc_r        <= NOP_PC;
            ir_r        <= NOP_IR;
        end else begin
            state_r     <= state_w;
            imem_addr_r <= imem_addr_w;
            next_pc_r   <= next_pc_w;
            if (bubble_w) begin
                pc_r <= NOP_PC;
                ir_r <= NOP_IR;
            end else if (issue_w) begin
                pc_r <= next_pc_r;
                ir_r <= expanded_ir_w;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (save_hi_w) begin
            saved_hi_r <= imem_data_i[31:16];
        end
        if (jump_w && jmp_addr_i[1]) begin
            jmp_addr_r <= jmp_addr_i;
        end
    end

    assign imem_addr_o = imem_addr_w; // memory registers it, data next cycle
    assign out.pc      = pc_r;
    assign out.ir      = ir_r;
    assign out.next_pc = next_pc_r;

    // targets are at least halfword aligned
    jmp_halfword_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        jmp_valid_i |-> !jmp_addr_i[0]);

    bubble_is_nop_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out.pc == NOP_PC |-> out.ir == NOP_IR);

    // back-pressure holds the instruction on offer
    stall_holds_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !out.ready && !halt_i |=> $stable(out.pc) && $stable(out.ir));

endmodule

`default_nettype wire

//--- src/imem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module imem_ram (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire rv_isa_pkg::word_t            addr_i,
    output rv_isa_pkg::word_t                 data_o,
    input  wire logic                         load_req_i,
    input  wire logic [fetch_pkg::IMEM_AW-1:0] load_addr_i,
    input  wire rv_isa_pkg::word_t            load_data_i,
    output logic                              load_ack_o
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    word_t mem_r [IMEM_WORDS];
    logic  write_w;

    // write once per request, on the edge that first sees it
    assign write_w = load_req_i && !load_ack_o;

    always_ff @(posedge clk_i) begin
        if (write_w) begin
            mem_r[load_addr_i] <= load_data_i;
        end
    end

    // registered read, byte address to word index
    always_ff @(posedge clk_i) begin
        data_o <= mem_r[addr_i[IMEM_AW+1:2]];
    end

    // ack follows req one edge later in both directions
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_ack_o <= 1'b0;
        end else begin
            load_ack_o <= load_req_i;
        end
    end

    ack_needs_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !load_req_i && !load_ack_o |=> !load_ack_o);

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic                         halt_i,
    input  wire logic                         ready_i,
    input  wire logic                         jmp_valid_i,
    input  wire rv_isa_pkg::word_t            jmp_addr_i,
    input  wire logic                         load_req_i,
    input  wire logic [fetch_pkg::IMEM_AW-1:0] load_addr_i,
    input  wire rv_isa_pkg::word_t            load_data_i,
    output logic                              load_ack_o,
    output rv_isa_pkg::word_t                 pc_o,
    output rv_isa_pkg::word_t                 ir_o,
    output rv_isa_pkg::word_t                 next_pc_o
);
    import rv_isa_pkg::*;

    word_t imem_addr_w;
    word_t imem_data_w;

    fetch_out_if out_if ();

    imem_ram imem_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .addr_i      (imem_addr_w),
        .data_o      (imem_data_w),
        .load_req_i  (load_req_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .load_ack_o  (load_ack_o)
    );

    fetch_stage fetch_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .halt_i      (halt_i),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .imem_addr_o (imem_addr_w),
        .imem_data_i (imem_data_w),
        .out         (out_if.stage)
    );

    // decode side as plain ports
    assign out_if.ready = ready_i;
    assign pc_o         = out_if.pc;
    assign ir_o         = out_if.ir;
    assign next_pc_o    = out_if.next_pc;

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1; // released after two edges
    end

    always #5 clk_o = ~clk_o; // 10 ns period

endmodule

`default_nettype wire

//--- testbench/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int TIMEOUT = 300; // cycles allowed per wait

    // mixed program, halfwords in address order from 0x40
    localparam logic [15:0] MIXED_HW [18] = '{
        16'h0085, 16'h0593, 16'h00c0, 16'h557d, 16'h6285, 16'h85b2,
        16'ha023, 16'h0020, 16'h95b2, 16'h4044, 16'hc404, 16'h0513,
        16'hfff0, 16'ha011, 16'h8082, 16'h0001, 16'h5037, 16'h1234
    };

    logic               clk_i;
    logic               rst_n_i;
    logic               halt_i;
    logic               ready_i;
    logic               jmp_valid_i;
    word_t              jmp_addr_i;
    logic               load_req_i;
    logic [IMEM_AW-1:0] load_addr_i;
    word_t              load_data_i;
    logic               load_ack_o;
    word_t              pc_o;
    word_t              ir_o;
    word_t              next_pc_o;

    logic [15:0] prog_hw[$]; // program copy, halfword 0 at prog_base
    word_t       prog_base;
    word_t       pc_q[$];
    word_t       ir_q[$];
    word_t       npc_q[$];
    int          error_count;
    int          test_count;
    int          test_fails;

    tb_clock_gen clk_gen_i (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    fetch_top dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .halt_i      (halt_i),
        .ready_i     (ready_i),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .load_req_i  (load_req_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .load_ack_o  (load_ack_o),
        .pc_o        (pc_o),
        .ir_o        (ir_o),
        .next_pc_o   (next_pc_o)
    );

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("tests: %0d, failed: %0d, errors: %0d", test_count, test_fails, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        error_count++;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        report_and_finish();
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            test_fails++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // hand-expanded compressed encodings
    function automatic word_t expected_expansion(input logic [15:0] hw);
        case (hw)
            16'h0001: return 32'h0000_0013; // c.nop
            16'h0085: return 32'h0010_8093; // c.addi x1, 1
            16'h557d: return 32'hfff0_0513; // c.li x10, -1
            16'h6285: return 32'h0000_12b7; // c.lui x5, 1
            16'h85b2: return 32'h00c0_05b3; // c.mv x11, x12
            16'h95b2: return 32'h00c5_85b3; // c.add x11, x12
            16'h4044: return 32'h0044_2483; // c.lw x9, 4(x8)
            16'hc404: return 32'h0094_2423; // c.sw x9, 8(x8)
            16'ha011: return 32'h0040_006f; // c.j +4
            default:  return 32'h0000_0000; // c.jr and the rest, illegal
        endcase
    endfunction

    // four-phase write of one word
    task automatic load_word(input logic [IMEM_AW-1:0] waddr, input word_t data);
        int t;
        @(posedge clk_i);
        load_req_i  <= 1'b1;
        load_addr_i <= waddr;
        load_data_i <= data;
        t = 0;
        while (load_ack_o !== 1'b1) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) abort_on_timeout("load ack rise");
        end
        // ack one cycle after req, seen here one edge later
        check_value("load ack rise latency", word_t'(t), 32'd2);
        load_req_i <= 1'b0;
        t = 0;
        while (load_ack_o !== 1'b0) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) abort_on_timeout("load ack fall");
        end
        check_value("load ack fall latency", word_t'(t), 32'd2);
    endtask

    task automatic load_program();
        @(posedge clk_i);
        halt_i <= 1'b1;
        for (int k = 0; k < prog_hw.size() / 2; k++) begin
            load_word(IMEM_AW'((prog_base >> 2) + k), {prog_hw[2*k+1], prog_hw[2*k]});
        end
    endtask

    task automatic jump_to(input word_t addr);
        @(posedge clk_i);
        halt_i      <= 1'b0;
        jmp_valid_i <= 1'b1;
        jmp_addr_i  <= addr;
        @(posedge clk_i);
        jmp_valid_i <= 1'b0; // sampled on this edge
    endtask

    // gathers transferred items, bubbles only until the target shows up
    task automatic collect_after_jump(input word_t target, input int count, input bit rand_ready);
        int    t;
        int    run_left;
        logic  seen_target;
        logic  ready_now;
        logic  last_ready;
        word_t last_pc;
        word_t last_ir;
        pc_q.delete();
        ir_q.delete();
        npc_q.delete();
        t           = 0;
        run_left    = 0;
        seen_target = 1'b0;
        ready_now   = 1'b1;
        last_ready  = 1'b1;
        last_pc     = pc_o;
        last_ir     = ir_o;
        while (pc_q.size() < count) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) abort_on_timeout("instruction stream");
            if (!last_ready) begin
                check_value("pc under back-pressure", pc_o, last_pc);
                check_value("ir under back-pressure", ir_o, last_ir);
            end
            if (ready_i && pc_o !== NOP_PC) begin
                if (pc_o === target) seen_target = 1'b1;
                if (seen_target) begin
                    pc_q.push_back(pc_o);
                    ir_q.push_back(ir_o);
                    npc_q.push_back(next_pc_o);
                end else begin
                    check_value("pc before jump target", pc_o, NOP_PC);
                end
            end
            last_ready = ready_i;
            last_pc    = pc_o;
            last_ir    = ir_o;
            if (rand_ready) begin
                if (run_left == 0) begin
                    ready_now = !ready_now;
                    run_left  = 1 + int'($urandom % 4); // run of 1 to 4 cycles
                end
                run_left--;
                ready_i <= ready_now;
            end
        end
        ready_i <= 1'b1;
    endtask

    // walks the program copy from start_pc
    task automatic expect_stream(input word_t start_pc, input int count);
        word_t       pc;
        word_t       ir;
        logic [15:0] lo;
        int          j;
        pc = start_pc;
        for (int k = 0; k < count; k++) begin
            j  = int'((pc - prog_base) >> 1);
            lo = prog_hw[j];
            if (lo[1:0] == 2'b11) begin
                ir = {prog_hw[j+1], lo};
                pc = pc + 32'd4;
            end else begin
                ir = expected_expansion(lo);
                pc = pc + 32'd2;
            end
            check_value("pc", pc_q[k], pc - ((lo[1:0] == 2'b11) ? 32'd4 : 32'd2));
            check_value("ir", ir_q[k], ir);
            check_value("next_pc", npc_q[k], pc);
        end
    endtask

    task automatic test_reset();
        int errs;
        int t;
        errs = error_count;
        t    = 0;
        while (rst_n_i !== 1'b1) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) abort_on_timeout("reset release");
        end
        check_value("pc after reset", pc_o, NOP_PC);
        check_value("ir after reset", ir_o, NOP_IR);
        check_value("next_pc after reset", next_pc_o, 32'd0);
        check_value("load ack after reset", {31'd0, load_ack_o}, 32'd0);
        end_test("reset", errs);
    endtask

    task automatic test_aligned();
        int    errs;
        word_t w;
        errs = error_count;
        prog_hw.delete();
        for (int k = 0; k < 8; k++) begin
            w = {12'(k * 3 + 1), 5'd0, 3'b000, 5'(k + 1), 7'h13}; // addi with rising imm
            prog_hw.push_back(w[15:0]);
            prog_hw.push_back(w[31:16]);
        end
        prog_base = 32'h0;
        load_program();
        jump_to(32'h0);
        collect_after_jump(32'h0, 8, 1'b0);
        expect_stream(32'h0, 8);
        end_test("aligned", errs);
    endtask

    task automatic test_mixed();
        int errs;
        errs = error_count;
        prog_hw.delete();
        foreach (MIXED_HW[k]) prog_hw.push_back(MIXED_HW[k]);
        prog_base = 32'h40;
        load_program();
        jump_to(32'h40);
        collect_after_jump(32'h40, 14, 1'b0);
        expect_stream(32'h40, 14);
        end_test("mixed", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = error_count;
        jump_to(32'h40);
        collect_after_jump(32'h40, 14, 1'b1);
        expect_stream(32'h40, 14);
        end_test("backpressure", errs);
    endtask

    task automatic test_jumps();
        int errs;
        errs = error_count;
        jump_to(32'h40);
        collect_after_jump(32'h40, 3, 1'b0);
        jump_to(32'h4c); // aligned target
        collect_after_jump(32'h4c, 5, 1'b0);
        expect_stream(32'h4c, 5);
        jump_to(32'h46); // halfword target, compressed
        collect_after_jump(32'h46, 4, 1'b0);
        expect_stream(32'h46, 4);
        jump_to(32'h56); // halfword target, spans two words
        collect_after_jump(32'h56, 5, 1'b0);
        expect_stream(32'h56, 5);
        end_test("jumps", errs);
    endtask

    task automatic test_halt();
        int errs;
        errs = error_count;
        jump_to(32'h40);
        collect_after_jump(32'h40, 4, 1'b0);
        @(posedge clk_i);
        halt_i <= 1'b1;
        @(posedge clk_i);
        for (int k = 0; k < 8; k++) begin
            @(posedge clk_i);
            check_value("pc while halted", pc_o, NOP_PC);
            check_value("ir while halted", ir_o, NOP_IR);
            if (k == 3) halt_i <= 1'b0; // only a jump leaves the halt
        end
        jump_to(32'h50);
        collect_after_jump(32'h50, 3, 1'b0);
        expect_stream(32'h50, 3);
        end_test("halt", errs);
    endtask

    initial begin
        void'($urandom(32'hd871));
        error_count = 0;
        test_count  = 0;
        test_fails  = 0;
        halt_i      = 1'b1;
        ready_i     = 1'b1;
        jmp_valid_i = 1'b0;
        jmp_addr_i  = '0;
        load_req_i  = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        test_reset();
        test_aligned();
        test_mixed();
        test_backpressure();
        test_jumps();
        test_halt();
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- flist.f
common/rv_isa_pkg.sv
common/fetch_pkg.sv
common/fetch_out_if.sv
fetch/rvc_expander.sv
fetch/fetch_stage.sv
src/imem_ram.sv
src/fetch_top.sv
testbench/tb_clock_gen.sv
testbench/tb_fetch_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fetch_top
FILELIST = flist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
